// ==== build.f ====
logic/vctrl_pkg.sv
logic/csr_if.sv
logic/req_buffer.sv
logic/vcsr_file.sv
logic/insn_tracker.sv
logic/issue_ctrl.sv
logic/vector_controller.sv
dv/vctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vector controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f build.f --top-module vctrl_tb -Mdir obj_dir -o vctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/vctrl_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
fi

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== dv/vctrl_trace.txt ====
# op unit csr_op csr_addr vtype rs1 rd use_rd kind e0 e1 e2 e3, all hex
# kind 0 result e0=data, kind 1 dispatch e0=unit e1=vl e2=vstart e3=vtype, kind 2 reject
2 1 0 0 00 00000000 00 0 2 0 0 0 0
1 0 0 2 00 00000000 05 1 0 40 0 0 0
0 0 0 0 0a 00000064 01 1 0 20 0 0 0
2 1 0 0 00 00000000 00 0 1 0 20 0 0a
0 0 0 0 01 0000000a 02 1 0 0a 0 0 0
1 0 0 1 00 00000000 03 1 0 0a 0 0 0
1 0 0 3 00 00000000 04 1 0 40 0 0 0
1 0 1 0 00 00000005 05 0 0 0 0 0 0
1 0 0 0 00 00000000 06 1 0 5 0 0 0
1 0 2 0 00 0000000a 07 1 0 5 0 0 0
1 0 3 0 00 00000003 08 1 0 f 0 0 0
2 3 0 0 00 00000000 00 0 1 2 0a c 01
2 1 0 0 00 00000000 00 0 1 0 0a 0 01
2 2 0 0 02 00000000 00 0 1 1 0a 0 02
0 0 0 0 38 ffffffff 09 1 0 20 0 0 0
1 0 0 2 00 00000000 0a 1 0 38 0 0 0
0 0 0 0 32 00000010 0b 1 0 0 0 0 0
1 0 0 2 00 00000000 0c 1 0 40 0 0 0
2 3 0 0 00 00000000 00 0 2 0 0 0 0
1 0 0 1 00 00000000 0d 1 0 0 0 0 0
0 0 0 0 03 ffffffff 0e 1 0 0 0 0 0
0 0 0 0 28 ffffffff 0f 1 0 0 0 0 0
0 0 0 0 20 ffffffff 10 1 0 0 0 0 0
0 0 0 0 1a ffffffff 11 1 0 80 0 0 0
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
2 2 0 0 09 00000000 00 0 1 1 80 0 09
2 3 0 0 00 00000000 00 0 1 2 80 0 1a
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
2 3 0 0 00 00000000 00 0 1 2 80 0 1a
2 2 0 0 00 00000000 00 0 1 1 80 0 00
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
2 3 0 0 00 00000000 00 0 1 2 80 0 1a
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
2 2 0 0 12 00000000 00 0 1 1 80 0 12
2 1 0 0 00 00000000 00 0 1 0 80 0 1a
1 0 1 0 00 00000007 12 0 0 0 0 0 0
2 1 0 0 00 00000000 00 0 1 0 80 7 1a
2 3 0 0 00 00000000 00 0 1 2 80 0 1a
1 0 0 1 00 00000000 13 1 0 80 0 0 0

// ==== dv/vctrl_tb.sv ====
module vctrl_tb
  import vctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLES_PER_LINE = 40;

  logic                clk_i;
  logic                arst_n_i;
  logic                issue_valid_i;
  vreq_t               issue_req_i;
  logic                issue_ready_o;
  logic [NR_UNITS-1:0] unit_ready_i;
  logic [NR_UNITS-1:0] unit_done_i;
  vid_t [NR_UNITS-1:0] unit_done_id_i;
  logic [NR_UNITS-1:0] unit_req_valid_o;
  vreq_t               unit_req_o;
  logic                result_valid_o;
  result_t             result_o;
  logic                reject_o;
  logic                busy_o;

  // Trace contents per instruction
  vreq_t               line_req[$];
  logic [1:0]          line_kind[$];
  logic [3:0][31:0]    line_exp[$];
  int                  pending[$];

  // Unit model and ID bookkeeping
  vid_t                unit_ids[NR_UNITS][$];
  int unsigned         unit_wait[NR_UNITS];
  logic [MAX_INSN-1:0] model_running = '0;
  int unsigned         lcg_state = 72012;
  int                  cycles = 0;
  int                  cycle_limit = 0;

  vector_controller #(.VLEN(512)) vector_controller_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .issue_valid_i    (issue_valid_i),
    .issue_req_i      (issue_req_i),
    .issue_ready_o    (issue_ready_o),
    .unit_ready_i     (unit_ready_i),
    .unit_done_i      (unit_done_i),
    .unit_done_id_i   (unit_done_id_i),
    .unit_req_valid_o (unit_req_valid_o),
    .unit_req_o       (unit_req_o),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o),
    .reject_o         (reject_o),
    .busy_o           (busy_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    string       text;
    logic [31:0] f[13];
    vreq_t       req;
    fd = $fopen("dv/vctrl_trace.txt", "r");
    if (fd == 0) abort_run("Could not open the trace file dv/vctrl_trace.txt");
    while (!$feof(fd)) begin
      if ($fgets(text, fd) == 0) break;
      if (text.len() < 2 || text.getc(0) == "#") continue;
      n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                  f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
      if (n != 13) abort_run({"Malformed trace line: ", text});
      req          = '0;
      req.op       = vop_e'(f[0][1:0]);
      req.ex_unit  = ex_unit_e'(f[1][1:0]);
      req.csr_op   = csr_op_e'(f[2][1:0]);
      req.csr_addr = csr_addr_e'(f[3][1:0]);
      req.vtype    = vtype_t'(f[4][6:0]);
      req.rs1      = f[5];
      req.rd       = f[6][4:0];
      req.use_rd   = f[7][0];
      line_req.push_back(req);
      line_kind.push_back(f[8][1:0]);
      line_exp.push_back({f[12], f[11], f[10], f[9]});
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Clock, reset and issue driver
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    arst_n_i      = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    load_trace();
    if (line_req.size() == 0) abort_run("The trace file holds no instructions");
    cycle_limit = CYCLES_PER_LINE * line_req.size() + 10;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    for (int i = 0; i < line_req.size(); i++) begin
      issue_valid_i = 1'b1;
      issue_req_i   = line_req[i];
      pending.push_back(i);
      do begin
        @(posedge clk_i);
      end while (!issue_ready_o);
      @(negedge clk_i);
    end
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    // Drain outstanding responses and running IDs
    while (pending.size() != 0 || busy_o) begin
      @(negedge clk_i);
    end
    check_value("running IDs at end", 32'd0, 32'(model_running));
    $display("Verification passed");
    $finish;
  end

  ////////////////////////////////////////
  // Execution unit model
  ////////////////////////////////////////

  initial begin
    unit_ready_i   = '0;
    unit_done_i    = '0;
    unit_done_id_i = '0;
    for (int u = 0; u < NR_UNITS; u++) unit_wait[u] = next_random() % 10;
    forever begin
      @(negedge clk_i);
      unit_done_i = '0;
      for (int u = 0; u < NR_UNITS; u++) begin
        // Ready drops about a third of the time
        unit_ready_i[u] = (next_random() % 3) != 0;
        if (unit_ids[u].size() != 0) begin
          if (unit_wait[u] != 0) begin
            unit_wait[u]--;
          end else begin
            unit_done_i[u]    = 1'b1;
            unit_done_id_i[u] = unit_ids[u].pop_front();
            unit_wait[u]      = next_random() % 10;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////

  initial begin
    int          idx;
    int          seen;
    int          held;
    logic        transfer;
    logic [31:0] exp_id;
    string       tag;
    held = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > cycle_limit) begin
        abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
      end
      check_value("busy level", 32'(model_running != '0), 32'(busy_o));
      seen = int'(result_valid_o) + int'(reject_o) + int'(unit_req_valid_o != '0);
      if (seen > 1) abort_run("More than one response pulse in the same cycle");
      transfer = issue_valid_i && issue_ready_o;
      // Ready while the buffer is empty or its head leaves
      check_value("issue ready", 32'((held == 0) || (seen == 1)), 32'(issue_ready_o));
      if (seen == 1) begin
        if (held == 0 && !transfer) abort_run("DUT responded with no instruction accepted");
        if (pending.size() == 0) abort_run("DUT responded with no instruction outstanding");
        idx = pending.pop_front();
        tag = $sformatf("insn %0d", idx + 1);
        if (result_valid_o) begin
          check_value({tag, " kind"}, 32'(line_kind[idx]), 32'd0);
          check_value({tag, " data"}, line_exp[idx][0], result_o.data);
          check_value({tag, " rd"}, 32'(line_req[idx].rd), 32'(result_o.rd));
        end else if (reject_o) begin
          check_value({tag, " kind"}, 32'(line_kind[idx]), 32'd2);
        end else begin
          check_value({tag, " kind"}, 32'(line_kind[idx]), 32'd1);
          // Expected ID is the lowest one not running
          exp_id = 32'hff;
          for (int i = MAX_INSN - 1; i >= 0; i--) begin
            if (!model_running[i]) exp_id = 32'(i);
          end
          check_value({tag, " unit"}, 32'd1 << line_exp[idx][0], 32'(unit_req_valid_o));
          check_value({tag, " id"}, exp_id, 32'(unit_req_o.id));
          check_value({tag, " vl"}, line_exp[idx][1], 32'(unit_req_o.vl));
          check_value({tag, " vstart"}, line_exp[idx][2], 32'(unit_req_o.vstart));
          check_value({tag, " vtype"}, line_exp[idx][3], 32'(unit_req_o.vtype));
          unit_ids[int'(line_exp[idx][0])].push_back(unit_req_o.id);
        end
      end
      held = held + int'(transfer) - seen;
      for (int u = 0; u < NR_UNITS; u++) begin
        if (unit_done_i[u]) model_running[unit_done_id_i[u]] = 1'b0;
      end
      if (unit_req_valid_o != '0) model_running[unit_req_o.id] = 1'b1;
    end
  end

endmodule

// ==== logic/vector_controller.sv ====
module vector_controller
  import vctrl_pkg::*;
#(
  parameter int unsigned VLEN = 512
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Issue from the front end
  input  logic                issue_valid_i,
  input  vreq_t               issue_req_i,
  output logic                issue_ready_o,
  // Execution units
  input  logic [NR_UNITS-1:0] unit_ready_i,
  input  logic [NR_UNITS-1:0] unit_done_i,
  input  vid_t [NR_UNITS-1:0] unit_done_id_i,
  output logic [NR_UNITS-1:0] unit_req_valid_o,
  output vreq_t               unit_req_o,
  // Back to the core
  output logic                result_valid_o,
  output result_t             result_o,
  output logic                reject_o,
  output logic                busy_o
);

  logic  buf_valid;
  vreq_t buf_req;
  logic  buf_pop;
  vid_t  free_id;
  logic  tracker_full;
  logic  alloc;

  csr_if csr_bus ();

  req_buffer req_buffer_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (issue_valid_i),
    .req_i    (issue_req_i),
    .ready_o  (issue_ready_o),
    .valid_o  (buf_valid),
    .req_o    (buf_req),
    .pop_i    (buf_pop)
  );

  vcsr_file #(.VLEN(VLEN)) vcsr_file_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .csr_p    (csr_bus.csr)
  );

  insn_tracker #(.NR_INSN(MAX_INSN)) insn_tracker_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .alloc_i   (alloc),
    .done_i    (unit_done_i),
    .done_id_i (unit_done_id_i),
    .free_id_o (free_id),
    .full_o    (tracker_full),
    .busy_o    (busy_o)
  );

  issue_ctrl #(.VLEN(VLEN)) issue_ctrl_inst (
    .buf_valid_i      (buf_valid),
    .buf_req_i        (buf_req),
    .pop_o            (buf_pop),
    .csr_p            (csr_bus.issue),
    .unit_ready_i     (unit_ready_i),
    .free_id_i        (free_id),
    .full_i           (tracker_full),
    .alloc_o          (alloc),
    .unit_req_valid_o (unit_req_valid_o),
    .unit_req_o       (unit_req_o),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o),
    .reject_o         (reject_o)
  );

endmodule

// ==== logic/issue_ctrl.sv ====
module issue_ctrl
  import vctrl_pkg::*;
#(
  parameter int unsigned VLEN = 512
) (
  input  logic                buf_valid_i,
  input  vreq_t               buf_req_i,
  output logic                pop_o,
  csr_if.issue                csr_p,
  input  logic [NR_UNITS-1:0] unit_ready_i,
  input  vid_t                free_id_i,
  input  logic                full_i,
  output logic                alloc_o,
  output logic [NR_UNITS-1:0] unit_req_valid_o,
  output vreq_t               unit_req_o,
  output logic                result_valid_o,
  output result_t             result_o,
  output logic                reject_o
);

  logic       is_con;
  logic [1:0] ex_code;
  logic [1:0] unit_idx;
  logic       unit_rdy;
  logic       dispatch;
  logic       retire;

  ////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////

  assign is_con   = buf_req_i.ex_unit == CON;
  assign ex_code  = buf_req_i.ex_unit;
  assign unit_idx = ex_code - 2'd1;

  always_comb begin
    unit_rdy = 1'b0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_idx == 2'(u)) unit_rdy = unit_ready_i[u];
    end
  end

  assign retire   = buf_valid_i && is_con;
  assign reject_o = buf_valid_i && !is_con && csr_p.vtype.vill;
  assign dispatch = buf_valid_i && !is_con && !csr_p.vtype.vill && unit_rdy && !full_i;

  assign pop_o        = retire || reject_o || dispatch;
  assign alloc_o      = dispatch;
  assign csr_p.commit = retire || dispatch;
  assign csr_p.req    = buf_req_i;

  ////////////////////////////////////////
  // Dispatch to units
  ////////////////////////////////////////

  always_comb begin
    unit_req_o        = buf_req_i;
    unit_req_o.id     = free_id_i;
    unit_req_o.vl     = csr_p.vl;
    unit_req_o.vstart = csr_p.vstart;
    // Loads and stores carry their own element width
    if (buf_req_i.ex_unit != LSU) unit_req_o.vtype = csr_p.vtype;

    unit_req_valid_o = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      unit_req_valid_o[u] = dispatch && (unit_idx == 2'(u));
    end
  end

  // Result word back to the core
  always_comb begin
    result_valid_o = retire;
    result_o.rd    = buf_req_i.rd;
    result_o.data  = '0;
    if (buf_req_i.op == VCFG) begin
      result_o.data = elen_t'(csr_p.cfg_vl);
    end else if (buf_req_i.op == VCSR && buf_req_i.use_rd) begin
      case (buf_req_i.csr_addr)
        VSTART:  result_o.data = elen_t'(csr_p.vstart);
        VL:      result_o.data = elen_t'(csr_p.vl);
        VTYPE:   result_o.data = elen_t'(csr_p.vtype);
        default: result_o.data = elen_t'(VLEN / 8);
      endcase
    end
  end

endmodule

// ==== logic/insn_tracker.sv ====
module insn_tracker
  import vctrl_pkg::*;
#(
  parameter int unsigned NR_INSN = MAX_INSN
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                alloc_i,
  input  logic [NR_UNITS-1:0] done_i,
  input  vid_t [NR_UNITS-1:0] done_id_i,
  output vid_t                free_id_o,
  output logic                full_o,
  output logic                busy_o
);

  logic [NR_INSN-1:0] running_q, running_d;

  // Lowest free slot wins
  always_comb begin
    free_id_o = '0;
    for (int i = NR_INSN - 1; i >= 0; i--) begin
      if (!running_q[i]) free_id_o = vid_t'(i);
    end
  end

  assign full_o = &running_q;
  assign busy_o = |running_q;

  always_comb begin
    running_d = running_q;
    if (alloc_i) running_d[free_id_o] = 1'b1;
    // Completions from any unit
    for (int u = 0; u < NR_UNITS; u++) begin
      if (done_i[u]) running_d[done_id_i[u]] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

endmodule

// ==== logic/vcsr_file.sv ====
module vcsr_file
  import vctrl_pkg::*;
#(
  parameter int unsigned VLEN = 512
) (
  input  logic clk_i,
  input  logic arst_n_i,
  csr_if.csr   csr_p
);

  localparam int unsigned VLEN_BYTES = VLEN / 8;
  // log2 of ELEN in bytes, bounds SEW against LMUL
  localparam int EW_LIMIT = $clog2(ELEN / 8);

  vlen_t  vstart_q, vstart_d;
  vlen_t  vl_q, vl_d;
  vtype_t vtype_q, vtype_d;

  int     lmul_log2;
  logic   cfg_illegal;
  vlen_t  vlmax;
  vlen_t  cfg_vl;

  ////////////////////////////////////////
  // Configuration check
  ////////////////////////////////////////

  always_comb begin
    lmul_log2   = int'($signed(csr_p.req.vtype.vlmul));
    cfg_illegal = (csr_p.req.vtype.vsew > MAX_EW) ||
                  (csr_p.req.vtype.vlmul inside {LMUL_RES, LMUL_F8}) ||
                  (int'(csr_p.req.vtype.vsew) > lmul_log2 + EW_LIMIT);
  end

  // Elements per register, then grouped by LMUL
  always_comb begin
    vlmax = vlen_t'(VLEN_BYTES) >> csr_p.req.vtype.vsew;
    case (csr_p.req.vtype.vlmul)
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_F2: vlmax = vlmax >> 1;
      default: vlmax = vlmax;
    endcase
  end

  // All ones in rs1 asks for the maximum
  always_comb begin
    if (cfg_illegal) begin
      cfg_vl = '0;
    end else if (csr_p.req.rs1 == '1) begin
      cfg_vl = vlmax;
    end else if (csr_p.req.rs1 < elen_t'(vlmax)) begin
      cfg_vl = vlen_t'(csr_p.req.rs1);
    end else begin
      cfg_vl = vlmax;
    end
  end

  ////////////////////////////////////////
  // Register update
  ////////////////////////////////////////

  always_comb begin
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;

    if (csr_p.commit) begin
      case (csr_p.req.op)
        VCFG: begin
          vl_d = cfg_vl;
          if (cfg_illegal) begin
            vtype_d = VTYPE_ILLEGAL;
          end else begin
            vtype_d      = csr_p.req.vtype;
            vtype_d.vill = 1'b0;
          end
        end
        VCSR: begin
          case (csr_p.req.csr_op)
            WRITE:   vstart_d = vlen_t'(csr_p.req.rs1);
            SET:     vstart_d = vstart_q | vlen_t'(csr_p.req.rs1);
            CLEAR:   vstart_d = vstart_q & ~vlen_t'(csr_p.req.rs1);
            default: vstart_d = vstart_q;
          endcase
        end
        default: vstart_d = vstart_q;
      endcase

      // Unit work restarts from element zero next time
      if (csr_p.req.ex_unit != CON) vstart_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= VTYPE_ILLEGAL;
    end else begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  assign csr_p.vstart = vstart_q;
  assign csr_p.vl     = vl_q;
  assign csr_p.vtype  = vtype_q;
  assign csr_p.cfg_vl = cfg_vl;

endmodule

// ==== logic/req_buffer.sv ====
module req_buffer
  import vctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  push_i,
  input  vreq_t req_i,
  output logic  ready_o,
  output logic  valid_o,
  output vreq_t req_o,
  input  logic  pop_i
);

  logic  full_q;
  vreq_t data_q;
  logic  accept;

  // Room when empty or the head leaves this cycle
  assign ready_o = !full_q || pop_i;
  assign accept  = push_i && ready_o;

  // Fall through while empty
  assign valid_o = full_q || push_i;
  assign req_o   = full_q ? data_q : req_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (pop_i) full_q <= accept;
    end else begin
      full_q <= accept && !pop_i;
    end
  end

  // Only store what did not pass straight through
  always_ff @(posedge clk_i) begin
    if (accept && (full_q || !pop_i)) data_q <= req_i;
  end

endmodule

// ==== logic/csr_if.sv ====
interface csr_if
  import vctrl_pkg::*;
();

  // Issue side
  logic   commit;
  vreq_t  req;

  // Register file side
  vlen_t  vl;
  vtype_t vtype;
  vlen_t  vstart;
  vlen_t  cfg_vl;

  modport issue (
    output commit, req,
    input  vl, vtype, vstart, cfg_vl
  );

  modport csr (
    input  commit, req,
    output vl, vtype, vstart, cfg_vl
  );

endinterface

// ==== logic/vctrl_pkg.sv ====
package vctrl_pkg;

  ////////////////////////////////////////
  // Design constants
  ////////////////////////////////////////

  localparam int unsigned ELEN     = 32;
  localparam int unsigned MAX_INSN = 4;
  localparam int unsigned NR_UNITS = 3;

  typedef logic [$clog2(MAX_INSN)-1:0] vid_t;
  typedef logic [15:0]                 vlen_t;
  typedef logic [ELEN-1:0]             elen_t;

  ////////////////////////////////////////
  // Vector type
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2,
    EW_64 = 3'd3
  } vsew_e;

  // Widest element the datapath handles
  localparam vsew_e MAX_EW = EW_32;

  // Fractional codes read as negative when taken as signed
  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    vlmul_e vlmul;
    vsew_e  vsew;
  } vtype_t;

  localparam vtype_t VTYPE_ILLEGAL = '{vill: 1'b1, vlmul: LMUL_1, vsew: EW_8};

  ////////////////////////////////////////
  // Request and result words
  ////////////////////////////////////////

  typedef enum logic [1:0] {CON, VFU, LSU, SLD} ex_unit_e;
  typedef enum logic [1:0] {VCFG, VCSR, VEXEC} vop_e;
  typedef enum logic [1:0] {READ, WRITE, SET, CLEAR} csr_op_e;
  typedef enum logic [1:0] {VSTART, VL, VTYPE, VLENB} csr_addr_e;

  typedef struct packed {
    vop_e      op;
    ex_unit_e  ex_unit;
    csr_op_e   csr_op;
    csr_addr_e csr_addr;
    vtype_t    vtype;
    elen_t     rs1;
    logic [4:0] rd;
    logic      use_rd;
    vid_t      id;
    vlen_t     vl;
    vlen_t     vstart;
  } vreq_t;

  typedef struct packed {
    logic [4:0] rd;
    elen_t      data;
  } result_t;

endpackage
